//--- rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int WORD_W = 32;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] addr_t;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

//--- rtl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // signed
        ALU_PASS_B,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // one hold bit per stage register
    typedef logic [3:0] stall_t;

    localparam int STALL_PC    = 0;
    localparam int STALL_IFID  = 1;
    localparam int STALL_IDEX  = 2;
    localparam int STALL_EXMEM = 3;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter mips_isa_pkg::addr_t RESET_PC = '0
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire pipe_ctrl_pkg::stall_t stall_i,
    input  wire logic                 branch_taken_i,
    input  wire mips_isa_pkg::addr_t  branch_target_i,
    input  wire mips_isa_pkg::word_t  inst_i,
    output mips_isa_pkg::addr_t       pc_o,
    output logic                      ce_o,
    output mips_isa_pkg::addr_t       id_pc_o,
    output mips_isa_pkg::word_t       id_inst_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    addr_t pc_q;
    logic  ce_q;
    addr_t id_pc_q;
    word_t id_inst_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ce_q <= 1'b0;
            pc_q <= RESET_PC;
        end else begin
            ce_q <= 1'b1; // fetch starts one cycle after release
            if (ce_q && !stall_i[STALL_PC]) begin
                pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
            end
        end
    end

    // IF/ID, all-zero word decodes as a no-op
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_pc_q   <= '0;
            id_inst_q <= '0;
        end else if (!stall_i[STALL_IFID]) begin
            id_pc_q   <= pc_q;
            id_inst_q <= ce_q ? inst_i : '0;
        end
    end

    assign pc_o      = pc_q;
    assign ce_o      = ce_q;
    assign id_pc_o   = id_pc_q;
    assign id_inst_o = id_inst_q;

    // branch offsets are word shifted, so redirects stay aligned
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire mips_isa_pkg::addr_t     pc_i,
    input  wire mips_isa_pkg::word_t     inst_i,
    input  wire mips_isa_pkg::word_t     rdata1_i,
    input  wire mips_isa_pkg::word_t     rdata2_i,
    input  wire pipe_ctrl_pkg::reg_addr_t ex_waddr_i,
    input  wire pipe_ctrl_pkg::mem_op_e  ex_mem_op_i,
    output pipe_ctrl_pkg::reg_addr_t     raddr1_o,
    output pipe_ctrl_pkg::reg_addr_t     raddr2_o,
    output logic                         re1_o,
    output logic                         re2_o,
    output pipe_ctrl_pkg::alu_op_e       alu_op_o,
    output mips_isa_pkg::word_t          op1_o,
    output mips_isa_pkg::word_t          op2_o,
    output mips_isa_pkg::word_t          store_data_o,
    output pipe_ctrl_pkg::reg_addr_t     waddr_o,
    output logic                         wreg_o,
    output pipe_ctrl_pkg::mem_op_e       mem_op_o,
    output logic                         branch_taken_o,
    output mips_isa_pkg::addr_t          branch_target_o,
    output pipe_ctrl_pkg::stall_t        stall_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    reg_addr_t   rs, rt, rd;
    logic [15:0] imm16;
    word_t       imm;
    logic        use_imm;
    logic        is_beq, is_bne;
    logic        load_use;

    assign opcode = opcode_e'(inst_i[OPCODE_LSB +: 6]);
    assign funct  = funct_e'(inst_i[FUNCT_LSB +: 6]);
    assign rs     = inst_i[RS_LSB +: 5];
    assign rt     = inst_i[RT_LSB +: 5];
    assign rd     = inst_i[RD_LSB +: 5];
    assign imm16  = inst_i[IMM_LSB +: 16];

    always_comb begin
        alu_op_o = ALU_NOP;
        mem_op_o = MEM_NONE;
        re1_o    = 1'b0;
        re2_o    = 1'b0;
        wreg_o   = 1'b0;
        waddr_o  = rt;
        use_imm  = 1'b1;
        imm      = {{16{imm16[15]}}, imm16}; // sign extended by default
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                re1_o   = 1'b1;
                re2_o   = 1'b1;
                wreg_o  = 1'b1;
                waddr_o = rd;
                use_imm = 1'b0;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: wreg_o = 1'b0; // unsupported, e.g. sll nop
                endcase
            end
            OP_ADDIU: begin
                re1_o    = 1'b1;
                wreg_o   = 1'b1;
                alu_op_o = ALU_ADD;
            end
            OP_ORI: begin
                re1_o    = 1'b1;
                wreg_o   = 1'b1;
                alu_op_o = ALU_OR;
                imm      = {16'h0000, imm16};
            end
            OP_LUI: begin
                wreg_o   = 1'b1;
                alu_op_o = ALU_PASS_B;
                imm      = {imm16, 16'h0000};
            end
            OP_LW: begin
                re1_o    = 1'b1;
                wreg_o   = 1'b1;
                alu_op_o = ALU_ADD;
                mem_op_o = MEM_LOAD;
            end
            OP_SW: begin
                re1_o    = 1'b1;
                re2_o    = 1'b1;
                alu_op_o = ALU_ADD; // address = base + offset
                mem_op_o = MEM_STORE;
            end
            OP_BEQ, OP_BNE: begin
                re1_o  = 1'b1;
                re2_o  = 1'b1;
                is_beq = (opcode == OP_BEQ);
                is_bne = (opcode == OP_BNE);
            end
            default: ;
        endcase
        if (!wreg_o) begin
            waddr_o = '0;
        end
    end

    assign raddr1_o     = rs;
    assign raddr2_o     = rt;
    assign op1_o        = rdata1_i;
    assign op2_o        = use_imm ? imm : rdata2_i;
    assign store_data_o = rdata2_i;

    // load in EX feeding a source read here
    assign load_use = (ex_mem_op_i == MEM_LOAD) && (ex_waddr_i != '0) &&
                      ((re1_o && raddr1_o == ex_waddr_i) || (re2_o && raddr2_o == ex_waddr_i));

    always_comb begin
        stall_o              = '0;
        stall_o[STALL_PC]    = load_use;
        stall_o[STALL_IFID]  = load_use;
        stall_o[STALL_IDEX]  = load_use;
    end

    // operands are stale while stalled, so no redirect then
    assign branch_taken_o  = !load_use &&
                             ((is_beq && rdata1_i == rdata2_i) || (is_bne && rdata1_i != rdata2_i));
    assign branch_target_o = pc_i + 32'd4 + {{14{imm16[15]}}, imm16, 2'b00};

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire logic                     we_i,
    input  wire pipe_ctrl_pkg::reg_addr_t waddr_i,
    input  wire mips_isa_pkg::word_t      wdata_i,
    input  wire logic                     ex_we_i,
    input  wire pipe_ctrl_pkg::reg_addr_t ex_waddr_i,
    input  wire mips_isa_pkg::word_t      ex_wdata_i,
    input  wire logic                     mem_we_i,
    input  wire pipe_ctrl_pkg::reg_addr_t mem_waddr_i,
    input  wire mips_isa_pkg::word_t      mem_wdata_i,
    input  wire logic                     re1_i,
    input  wire pipe_ctrl_pkg::reg_addr_t raddr1_i,
    input  wire logic                     re2_i,
    input  wire pipe_ctrl_pkg::reg_addr_t raddr2_i,
    output mips_isa_pkg::word_t           rdata1_o,
    output mips_isa_pkg::word_t           rdata2_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t regs [1:31]; // r0 is not stored

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // youngest result wins
    function automatic word_t read_port(input logic re, input reg_addr_t addr);
        if (!re || addr == '0)                      return '0;
        else if (ex_we_i && ex_waddr_i == addr)     return ex_wdata_i;
        else if (mem_we_i && mem_waddr_i == addr)   return mem_wdata_i;
        else if (we_i && waddr_i == addr)           return wdata_i; // write-first
        else                                        return regs[addr];
    endfunction

    always_comb rdata1_o = read_port(re1_i, raddr1_i);
    always_comb rdata2_o = read_port(re2_i, raddr2_i);

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire pipe_ctrl_pkg::stall_t    stall_i,
    input  wire pipe_ctrl_pkg::alu_op_e   alu_op_i,
    input  wire mips_isa_pkg::word_t      op1_i,
    input  wire mips_isa_pkg::word_t      op2_i,
    input  wire mips_isa_pkg::word_t      store_data_i,
    input  wire pipe_ctrl_pkg::reg_addr_t waddr_i,
    input  wire logic                     wreg_i,
    input  wire pipe_ctrl_pkg::mem_op_e   mem_op_i,
    output pipe_ctrl_pkg::reg_addr_t      ex_waddr_o,
    output logic                          ex_wreg_o,
    output mips_isa_pkg::word_t           ex_result_o,
    output pipe_ctrl_pkg::mem_op_e        ex_mem_op_o,
    output mips_isa_pkg::word_t           mem_alu_res_o,
    output mips_isa_pkg::word_t           mem_store_data_o,
    output pipe_ctrl_pkg::reg_addr_t      mem_waddr_o,
    output logic                          mem_wreg_o,
    output pipe_ctrl_pkg::mem_op_e        mem_op_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    alu_op_e   ex_alu_op_q;
    mem_op_e   ex_mem_op_q;
    reg_addr_t ex_waddr_q;
    logic      ex_wreg_q;
    word_t     ex_op1_q, ex_op2_q, ex_store_q;
    word_t     alu_res;

    // ID/EX control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_alu_op_q <= ALU_NOP;
            ex_mem_op_q <= MEM_NONE;
            ex_waddr_q  <= '0;
            ex_wreg_q   <= 1'b0;
        end else if (stall_i[STALL_IDEX] && !stall_i[STALL_EXMEM]) begin
            ex_alu_op_q <= ALU_NOP; // bubble
            ex_mem_op_q <= MEM_NONE;
            ex_waddr_q  <= '0;
            ex_wreg_q   <= 1'b0;
        end else if (!stall_i[STALL_IDEX]) begin
            ex_alu_op_q <= alu_op_i;
            ex_mem_op_q <= mem_op_i;
            ex_waddr_q  <= waddr_i;
            ex_wreg_q   <= wreg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i[STALL_EXMEM]) begin
            ex_op1_q   <= op1_i;
            ex_op2_q   <= op2_i;
            ex_store_q <= store_data_i;
        end
    end

    always_comb begin
        case (ex_alu_op_q)
            ALU_ADD:    alu_res = ex_op1_q + ex_op2_q;
            ALU_SUB:    alu_res = ex_op1_q - ex_op2_q;
            ALU_AND:    alu_res = ex_op1_q & ex_op2_q;
            ALU_OR:     alu_res = ex_op1_q | ex_op2_q;
            ALU_XOR:    alu_res = ex_op1_q ^ ex_op2_q;
            ALU_SLT:    alu_res = {{(WORD_W-1){1'b0}}, $signed(ex_op1_q) < $signed(ex_op2_q)};
            ALU_PASS_B: alu_res = ex_op2_q;
            default:    alu_res = '0;
        endcase
    end

    assign ex_waddr_o  = ex_waddr_q;
    assign ex_wreg_o   = ex_wreg_q && (ex_mem_op_q != MEM_LOAD); // load data comes in MEM
    assign ex_result_o = alu_res;
    assign ex_mem_op_o = ex_mem_op_q;

    // EX/MEM
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_waddr_o <= '0;
            mem_wreg_o  <= 1'b0;
            mem_op_o    <= MEM_NONE;
        end else if (!stall_i[STALL_EXMEM]) begin
            mem_waddr_o <= ex_waddr_q;
            mem_wreg_o  <= ex_wreg_q;
            mem_op_o    <= ex_mem_op_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i[STALL_EXMEM]) begin
            mem_alu_res_o    <= alu_res;
            mem_store_data_o <= ex_store_q;
        end
    end

    // the bubble taken here removes the load from EX, so decode cannot repeat it
    a_stall_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i[STALL_IDEX] |=> !stall_i[STALL_IDEX]);

endmodule

`default_nettype wire

//--- rtl/mem_wb_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_unit (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire mips_isa_pkg::word_t      alu_res_i,
    input  wire mips_isa_pkg::word_t      store_data_i,
    input  wire pipe_ctrl_pkg::reg_addr_t waddr_i,
    input  wire logic                     wreg_i,
    input  wire pipe_ctrl_pkg::mem_op_e   mem_op_i,
    input  wire mips_isa_pkg::word_t      ram_data_i,
    output logic                          ram_ce_o,
    output logic                          ram_we_o,
    output mips_isa_pkg::addr_t           ram_addr_o,
    output mips_isa_pkg::word_t           ram_wdata_o,
    output mips_isa_pkg::word_t           mem_wdata_o,
    output logic                          mem_wreg_o,
    output logic                          wb_we_o,
    output pipe_ctrl_pkg::reg_addr_t      wb_waddr_o,
    output mips_isa_pkg::word_t           wb_wdata_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    // word access at the ALU address
    assign ram_ce_o    = (mem_op_i != MEM_NONE);
    assign ram_we_o    = (mem_op_i == MEM_STORE);
    assign ram_addr_o  = alu_res_i;
    assign ram_wdata_o = store_data_i;

    assign mem_wdata_o = (mem_op_i == MEM_LOAD) ? ram_data_i : alu_res_i;
    assign mem_wreg_o  = wreg_i;

    // MEM/WB
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o    <= 1'b0;
            wb_waddr_o <= '0;
        end else begin
            wb_we_o    <= wreg_i;
            wb_waddr_o <= waddr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_wdata_o <= mem_wdata_o;
    end

    // full-word stores only, no byte lanes
    a_we_has_ce: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ram_we_o |-> ram_ce_o && ram_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/mini_mips.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mips #(
    parameter mips_isa_pkg::addr_t RESET_PC = '0
) (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire mips_isa_pkg::word_t rom_data_i,
    input  wire mips_isa_pkg::word_t ram_data_i,
    output logic                     rom_ce_o,
    output mips_isa_pkg::addr_t      rom_addr_o,
    output logic                     ram_ce_o,
    output logic                     ram_we_o,
    output mips_isa_pkg::addr_t      ram_addr_o,
    output mips_isa_pkg::word_t      ram_wdata_o
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    stall_t    stall;
    logic      branch_taken;
    addr_t     branch_target;
    addr_t     id_pc;
    word_t     id_inst;

    // decode to regfile
    reg_addr_t raddr1, raddr2;
    logic      re1, re2;
    word_t     rdata1, rdata2;

    // decode to execute
    alu_op_e   id_alu_op;
    word_t     id_op1, id_op2, id_store_data;
    reg_addr_t id_waddr;
    logic      id_wreg;
    mem_op_e   id_mem_op;

    // EX results, bypass and hazard
    reg_addr_t ex_waddr;
    logic      ex_wreg;
    word_t     ex_result;
    mem_op_e   ex_mem_op;

    // EX/MEM
    word_t     mem_alu_res, mem_store_data, mem_wdata;
    reg_addr_t mem_waddr;
    logic      mem_wreg;
    logic      mem_byp_we;
    mem_op_e   mem_op;

    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .inst_i(rom_data_i), .pc_o(rom_addr_o), .ce_o(rom_ce_o),
        .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    decode_unit u_decode (
        .pc_i(id_pc), .inst_i(id_inst), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .ex_waddr_i(ex_waddr), .ex_mem_op_i(ex_mem_op),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .re1_o(re1), .re2_o(re2),
        .alu_op_o(id_alu_op), .op1_o(id_op1), .op2_o(id_op2), .store_data_o(id_store_data),
        .waddr_o(id_waddr), .wreg_o(id_wreg), .mem_op_o(id_mem_op),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target), .stall_o(stall)
    );

    regfile u_regfile (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .we_i(wb_we), .waddr_i(wb_waddr), .wdata_i(wb_wdata),
        .ex_we_i(ex_wreg), .ex_waddr_i(ex_waddr), .ex_wdata_i(ex_result),
        .mem_we_i(mem_byp_we), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata),
        .re1_i(re1), .raddr1_i(raddr1), .re2_i(re2), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    execute_unit u_execute (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall),
        .alu_op_i(id_alu_op), .op1_i(id_op1), .op2_i(id_op2), .store_data_i(id_store_data),
        .waddr_i(id_waddr), .wreg_i(id_wreg), .mem_op_i(id_mem_op),
        .ex_waddr_o(ex_waddr), .ex_wreg_o(ex_wreg), .ex_result_o(ex_result),
        .ex_mem_op_o(ex_mem_op), .mem_alu_res_o(mem_alu_res),
        .mem_store_data_o(mem_store_data), .mem_waddr_o(mem_waddr),
        .mem_wreg_o(mem_wreg), .mem_op_o(mem_op)
    );

    mem_wb_unit u_mem_wb (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .alu_res_i(mem_alu_res), .store_data_i(mem_store_data), .waddr_i(mem_waddr),
        .wreg_i(mem_wreg), .mem_op_i(mem_op), .ram_data_i(ram_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o),
        .ram_wdata_o(ram_wdata_o), .mem_wdata_o(mem_wdata), .mem_wreg_o(mem_byp_we),
        .wb_we_o(wb_we), .wb_waddr_o(wb_waddr), .wb_wdata_o(wb_wdata)
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
endmodule

`default_nettype wire

//--- verification/tb_mini_mips.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mips;
    import mips_isa_pkg::*;

    localparam int    RESET_CYCLES  = 16;
    localparam int    STORE_TIMEOUT = 64;
    localparam int    QUIET_CYCLES  = 24; // longer than the pipeline depth
    localparam addr_t FIRST_PC      = 32'h0; // default RESET_PC

    logic  clk;
    logic  rst_n;
    word_t rom [0:255];
    word_t ram [0:255];
    word_t rom_data;
    word_t ram_data;
    word_t ram_wdata;
    addr_t rom_addr;
    addr_t ram_addr;
    logic  rom_ce;
    logic  ram_ce;
    logic  ram_we;
    int    prog_len;

    // one entry per write strobe
    addr_t st_addr_q [$];
    word_t st_data_q [$];
    logic  st_ce_q [$];

    tb_clk_gen u_clk (.clk_o(clk));

    mini_mips u_dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .rom_data_i(rom_data), .ram_data_i(ram_data),
        .rom_ce_o(rom_ce), .rom_addr_o(rom_addr),
        .ram_ce_o(ram_ce), .ram_we_o(ram_we),
        .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata)
    );

    assign rom_data = rom[rom_addr[9:2]];
    assign ram_data = ram[ram_addr[9:2]];

    always @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
            st_addr_q.push_back(ram_addr);
            st_data_q.push_back(ram_wdata);
            st_ce_q.push_back(ram_ce);
        end
    end

    task automatic report_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s address got %08h expected %08h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s data got %08h expected %08h", $time, what, got, exp);
            report_failure();
        end
    endtask

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // reference semantics of the register forms
    function automatic word_t model_rtype(input funct_e fn, input word_t a, input word_t b);
        case (fn)
            FN_ADDU: return a + b;
            FN_SUBU: return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 'x;
        endcase
    endfunction

    task automatic emit_word(input word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic rtype(input funct_e fn, input int rd, input int rs, input int rt);
        emit_word({OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
    endtask

    // assembly order, op rt, rs, imm
    task automatic itype(input opcode_e op, input int rt, input int rs, input logic [15:0] imm);
        emit_word({op, 5'(rs), 5'(rt), imm});
    endtask

    task automatic load_const(input int r, input word_t v);
        itype(OP_LUI, r, 0, v[31:16]);
        itype(OP_ORI, r, r, v[15:0]);
    endtask

    task automatic store_word(input int rt, input int base, input int off);
        itype(OP_SW, rt, base, 16'(off));
    endtask

    task automatic halt_loop();
        itype(OP_BEQ, 0, 0, 16'hffff); // branches to itself
        emit_word('0);                 // delay slot nop
    endtask

    task automatic start_program();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
        prog_len = 0;
        st_addr_q.delete();
        st_data_q.delete();
        st_ce_q.delete();
    endtask

    task automatic run_program();
        repeat (RESET_CYCLES) @(posedge clk);
        compare_bit(rom_ce, 1'b0, "rom_ce_o in reset");
        compare_bit(ram_ce, 1'b0, "ram_ce_o in reset");
        compare_bit(ram_we, 1'b0, "ram_we_o in reset");
        compare_addr(rom_addr, FIRST_PC, "rom_addr_o in reset");
        rst_n <= 1'b1;
        @(negedge clk);
        compare_bit(rom_ce, 1'b0, "rom_ce_o at release");
        @(negedge clk);
        compare_bit(rom_ce, 1'b1, "rom_ce_o after release");
        compare_addr(rom_addr, FIRST_PC, "rom_addr_o first fetch");
    endtask

    task automatic expect_store(input addr_t exp_addr, input word_t exp_data, input string what);
        int    waited;
        addr_t got_addr;
        word_t got_data;
        logic  got_ce;
        waited = 0;
        while (st_addr_q.size() == 0 && waited < STORE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (st_addr_q.size() == 0) begin
            $display("no store arrived within %0d cycles, waited for %s at %08h",
                     STORE_TIMEOUT, what, exp_addr);
            report_failure();
        end else begin
            got_addr = st_addr_q.pop_front();
            got_data = st_data_q.pop_front();
            got_ce   = st_ce_q.pop_front();
            compare_bit(got_ce, 1'b1, {what, " ram_ce_o"});
            compare_addr(got_addr, exp_addr, what);
            compare_word(got_data, exp_data, what);
        end
    endtask

    // program sits in its halt loop, nothing may be written any more
    task automatic expect_quiet(input string what);
        int n;
        n = 0;
        while (n < QUIET_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (st_addr_q.size() != 0) begin
            $display("unexpected store to %08h after the last store of %s", st_addr_q[0], what);
            report_failure();
        end
    endtask

    task automatic alu_ops_test();
        funct_e ops [0:5];
        word_t  a;
        word_t  b;
        addr_t  base;
        ops  = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
        a    = $urandom | 32'h8000_0000; // negative, so slt differs from unsigned
        b    = $urandom & 32'h7fff_ffff;
        base = 32'h40;
        start_program();
        load_const(1, a);
        load_const(2, b);
        load_const(4, base);
        for (int k = 0; k < 6; k++) begin
            rtype(ops[k], 3, 1, 2);
            store_word(3, 4, 4 * k);
        end
        rtype(FN_SLT, 3, 2, 1);
        store_word(3, 4, 24);
        halt_loop();
        run_program();
        for (int k = 0; k < 6; k++) begin
            expect_store(base + 4 * k, model_rtype(ops[k], a, b), ops[k].name());
        end
        expect_store(base + 24, model_rtype(FN_SLT, b, a), "slt reversed");
        expect_quiet("alu ops");
    endtask

    task automatic dependency_test();
        word_t       x;
        word_t       r6;
        word_t       r9;
        word_t       r11;
        logic [15:0] i1;
        logic [15:0] i2;
        logic [15:0] i3;
        logic [15:0] i4;
        logic [15:0] i5;
        addr_t       base;
        x    = $urandom;
        i1   = 16'($urandom);
        i2   = 16'($urandom);
        i3   = 16'($urandom);
        i4   = 16'($urandom);
        i5   = 16'($urandom);
        base = 32'h60;
        r6   = 3 * (x + sext16(i1) + sext16(i2));
        r9   = r6 + sext16(i3) + sext16(i4);
        r11  = 2 * (r9 + sext16(i5));
        start_program();
        load_const(4, base);
        load_const(5, x);
        itype(OP_ADDIU, 5, 5, i1);
        itype(OP_ADDIU, 5, 5, i2);
        rtype(FN_ADDU, 6, 5, 5);
        rtype(FN_ADDU, 6, 6, 5);
        store_word(6, 4, 0);       // store data from EX
        itype(OP_ADDIU, 7, 6, i3);
        itype(OP_ADDIU, 8, 0, i4);
        rtype(FN_ADDU, 9, 7, 8);   // r7 from MEM, r8 from EX
        store_word(9, 4, 4);
        itype(OP_ADDIU, 10, 9, i5);
        emit_word('0);
        emit_word('0);
        rtype(FN_ADDU, 11, 10, 10); // r10 through write-back
        store_word(11, 4, 8);
        halt_loop();
        run_program();
        expect_store(base, r6, "ex bypass chain");
        expect_store(base + 4, r9, "mem bypass");
        expect_store(base + 8, r11, "wb bypass");
        expect_quiet("dependency chain");
    endtask

    task automatic load_use_test();
        word_t v;
        word_t w;
        addr_t base;
        v    = $urandom;
        w    = $urandom;
        base = 32'h80;
        start_program();
        load_const(2, base);
        load_const(1, v);
        load_const(5, w);
        store_word(1, 2, 0);
        itype(OP_LW, 3, 2, 16'd0);
        rtype(FN_ADDU, 4, 3, 5);   // rs waits for the load
        store_word(4, 2, 4);
        itype(OP_LW, 6, 2, 16'd0);
        store_word(6, 2, 8);       // store data waits for the load
        itype(OP_LW, 7, 2, 16'd0);
        rtype(FN_SUBU, 8, 5, 7);   // rt side
        store_word(8, 2, 12);
        halt_loop();
        run_program();
        expect_store(base, v, "store before load");
        expect_store(base + 4, v + w, "load then addu");
        expect_store(base + 8, v, "load then sw");
        expect_store(base + 12, w - v, "load then subu");
        expect_quiet("load-use");
    endtask

    task automatic branch_test();
        word_t a;
        word_t b;
        addr_t base;
        a    = $urandom;
        b    = ~a;
        base = 32'hc0;
        start_program();
        load_const(4, base);
        load_const(1, a);
        load_const(2, a);
        load_const(3, b);
        // each branch skips one word, so offset 2 from the delay slot
        itype(OP_BEQ, 2, 1, 16'd2); // taken
        store_word(1, 4, 0);        // delay slot
        store_word(1, 4, 4);        // skipped
        store_word(2, 4, 8);
        itype(OP_BNE, 3, 1, 16'd2); // taken
        store_word(3, 4, 12);
        store_word(3, 4, 16);       // skipped
        store_word(3, 4, 20);
        itype(OP_BEQ, 3, 1, 16'd2); // not taken
        store_word(1, 4, 24);
        store_word(2, 4, 28);
        store_word(3, 4, 32);
        itype(OP_BNE, 2, 1, 16'd2); // not taken
        store_word(2, 4, 36);
        store_word(1, 4, 40);
        store_word(3, 4, 44);
        halt_loop();
        run_program();
        expect_store(base, a, "beq taken delay slot");
        expect_store(base + 8, a, "beq taken target");
        expect_store(base + 12, b, "bne taken delay slot");
        expect_store(base + 20, b, "bne taken target");
        expect_store(base + 24, a, "beq not taken delay slot");
        expect_store(base + 28, a, "beq not taken fall-through");
        expect_store(base + 32, b, "beq not taken next");
        expect_store(base + 36, a, "bne not taken delay slot");
        expect_store(base + 40, a, "bne not taken fall-through");
        expect_store(base + 44, b, "bne not taken next");
        expect_quiet("branches");
    endtask

    task automatic zero_reg_test();
        word_t y;
        addr_t base;
        y    = $urandom | 32'd1;
        base = 32'h100;
        start_program();
        load_const(4, base);
        load_const(2, y);
        itype(OP_ADDIU, 0, 0, 16'h1234);
        rtype(FN_ADDU, 1, 0, 0);
        store_word(0, 4, 0);
        store_word(1, 4, 4);
        rtype(FN_OR, 0, 2, 2);      // r0 write still in EX
        store_word(0, 4, 8);
        itype(OP_LUI, 0, 0, 16'hffff);
        rtype(FN_ADDU, 3, 0, 2);
        store_word(3, 4, 12);
        halt_loop();
        run_program();
        expect_store(base, '0, "sw r0");
        expect_store(base + 4, '0, "addu of r0");
        expect_store(base + 8, '0, "r0 after or");
        expect_store(base + 12, y, "r0 after lui");
        expect_quiet("r0");
    endtask

    initial begin
        rst_n    = 1'b0;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
            ram[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
        end
        void'($urandom(32'h4aa5));
        alu_ops_test();
        dependency_test();
        load_use_test();
        branch_test();
        zero_reg_test();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mips_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/regfile.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/mini_mips.sv
verification/tb_clk_gen.sv
verification/tb_mini_mips.sv

//--- Bender.yml
package:
  name: mini_mips

dependencies: {}

sources:
  - files:
      - rtl/mips_isa_pkg.sv
      - rtl/pipe_ctrl_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/decode_unit.sv
      - rtl/regfile.sv
      - rtl/execute_unit.sv
      - rtl/mem_wb_unit.sv
      - rtl/mini_mips.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_mini_mips.sv
